// File: Makefile
# Verilator build for the RV32I execute slice

VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
INCLUDES := $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(INCLUDES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulator exit status is the test verdict
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: include/alu_define.svh
`ifndef ALU_DEFINE_SVH
`define ALU_DEFINE_SVH

// bit 30 of the word picks the right shift flavour
typedef enum logic {
	logical    = 1'b0,
	arithmetic = 1'b1
} shift_type_t;

// register-register funct3
localparam funct3_t ADD   = 3'b000; // SUB shares it, told apart by bit 30
localparam funct3_t SUB   = 3'b000;
localparam funct3_t SLL   = 3'b001;
localparam funct3_t SLT   = 3'b010;
localparam funct3_t SLTU  = 3'b011;
localparam funct3_t XOR   = 3'b100;
localparam funct3_t SRL   = 3'b101;
localparam funct3_t SRA   = 3'b101;
localparam funct3_t OR    = 3'b110;
localparam funct3_t AND   = 3'b111;

// register-immediate funct3
localparam funct3_t ADDI  = 3'b000;
localparam funct3_t SLLI  = 3'b001;
localparam funct3_t SLTI  = 3'b010;
localparam funct3_t SLTIU = 3'b011;
localparam funct3_t XORI  = 3'b100;
localparam funct3_t SRLI  = 3'b101;
localparam funct3_t SRAI  = 3'b101;
localparam funct3_t ORI   = 3'b110;
localparam funct3_t ANDI  = 3'b111;

// conditional branch funct3
localparam funct3_t BEQ   = 3'b000;
localparam funct3_t BNE   = 3'b001;
localparam funct3_t BLT   = 3'b100;
localparam funct3_t BGE   = 3'b101;
localparam funct3_t BLTU  = 3'b110;
localparam funct3_t BGEU  = 3'b111;

`endif

// File: src.f
+incdir+include
src/rv_pkg.sv
src/instr_decode.sv
src/alu.sv
src/branch_unit.sv
src/writeback_reg.sv
src/exec_top.sv
testbench/clk_gen.sv
testbench/tb_exec_top.sv

// File: src/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
	input  dec_t  dec,
	output data_t c_out,
	output logic  rd_wr
);

	data_t and_result;
	data_t or_result;
	data_t xor_result;
	data_t shift_result;
	data_t add_sub_result;
	data_t adder_b;

	logic [4:0]  shamt;
	shift_type_t shift_type;
	logic        sub_func;
	logic        lt_signed;
	logic        lt_unsigned;

	always_comb begin
		shamt      = dec.b[4:0];
		shift_type = shift_type_t'(dec.alt); // 0 logical, 1 arithmetic
		sub_func   = (dec.opcode == R) & dec.alt & (dec.funct3 == SUB);
	end

	always_comb begin : logic_ops
		and_result = dec.a & dec.b;
		or_result  = dec.a | dec.b;
		xor_result = dec.a ^ dec.b;
	end

	always_comb begin : add_suber
		adder_b        = sub_func ? ~dec.b : dec.b;
		add_sub_result = dec.a + adder_b + data_t'(sub_func); // a - b = a + ~b + 1
	end

	always_comb begin : seter
		lt_signed   = $signed(dec.a) < $signed(dec.b);
		lt_unsigned = dec.a < dec.b;
	end

	always_comb begin : shifter
		unique case ({shift_type, dec.funct3, dec.opcode})
			{logical, SLL, R}:     shift_result = dec.a << shamt;
			{logical, SRL, R}:     shift_result = dec.a >> shamt;
			{arithmetic, SRA, R}:  shift_result = data_t'($signed(dec.a) >>> shamt);
			{logical, SLLI, I}:    shift_result = dec.a << shamt;
			{logical, SRLI, I}:    shift_result = dec.a >> shamt;
			{arithmetic, SRAI, I}: shift_result = data_t'($signed(dec.a) >>> shamt);
			default:               shift_result = '0;
		endcase
	end

	always_comb begin : output_sel
		c_out = '0;
		rd_wr = 1'b0;
		unique case (dec.opcode)
			R: begin
				unique case (dec.funct3)
					ADD:  c_out = add_sub_result; // SUB too
					SLL:  c_out = shift_result;
					SLT:  c_out = data_t'(lt_signed);
					SLTU: c_out = data_t'(lt_unsigned);
					XOR:  c_out = xor_result;
					SRL:  c_out = shift_result;   // SRA too
					OR:   c_out = or_result;
					AND:  c_out = and_result;
				endcase
				rd_wr = dec.valid;
			end
			I: begin
				unique case (dec.funct3)
					ADDI:  c_out = add_sub_result;
					SLLI:  c_out = shift_result;
					SLTI:  c_out = data_t'(lt_signed);
					SLTIU: c_out = data_t'(lt_unsigned);
					XORI:  c_out = xor_result;
					SRLI:  c_out = shift_result;
					ORI:   c_out = or_result;
					ANDI:  c_out = and_result;
				endcase
				rd_wr = dec.valid;
			end
			LUI: begin
				c_out = dec.b;                // already shifted up by decode
				rd_wr = dec.valid;
			end
			AUIPC, JAL, JALR, LOAD: begin
				c_out = add_sub_result;       // pc+imm, link pc+4 or load address
				rd_wr = dec.valid;
			end
			STORE: c_out = add_sub_result;    // address only
			B, MEM, SYS: c_out = '0;
			default: c_out = '0;
		endcase
	end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import rv_pkg::*; (
	input  dec_t  dec,
	output logic  taken,
	output data_t target
);

	logic  eq;
	logic  lt_signed;
	logic  lt_unsigned;
	logic  cond;
	data_t base;
	data_t sum;

	always_comb begin : compare
		eq          = dec.rs1_val == dec.rs2_val;
		lt_signed   = $signed(dec.rs1_val) < $signed(dec.rs2_val);
		lt_unsigned = dec.rs1_val < dec.rs2_val;
		unique case (dec.funct3)
			BEQ:     cond = eq;
			BNE:     cond = !eq;
			BLT:     cond = lt_signed;
			BGE:     cond = !lt_signed;
			BLTU:    cond = lt_unsigned;
			BGEU:    cond = !lt_unsigned;
			default: cond = 1'b0;     // 010 and 011 are not branches
		endcase
	end

	// own adder, the ALU is busy with pc+4 on jumps
	always_comb begin : target_gen
		base = (dec.opcode == JALR) ? dec.rs1_val : dec.pc;
		sum  = base + dec.imm;
		unique case (dec.opcode)
			B: begin
				taken  = cond;
				target = sum;
			end
			JAL: begin
				taken  = 1'b1;
				target = sum;
			end
			JALR: begin
				taken  = 1'b1;
				target = {sum[XLEN-1:1], 1'b0};
			end
			default: begin
				taken  = 1'b0;
				target = sum;
			end
		endcase
	end

	// B and JAL offsets are even, so a misaligned pc shows up here
	always_comb begin
		a_target_aligned: assert final (!(dec.valid && taken) || !target[0])
			else $error("branch_unit: odd redirect target %h", target);
	end

endmodule

// File: src/exec_top.sv
`timescale 1ns/1ps

module exec_top import rv_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   instr_valid,
	input  instr_t instr,
	input  data_t  pc,
	input  data_t  rs1_data,
	input  data_t  rs2_data,
	output wb_t    wb,
	output redir_t redir
);

	dec_t  dec;
	data_t alu_result;
	logic  alu_rd_wr;
	logic  br_taken;
	data_t br_target;

	instr_decode u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.dec         (dec)
	);

	alu u_alu (
		.dec   (dec),
		.c_out (alu_result),
		.rd_wr (alu_rd_wr)
	);

	branch_unit u_branch (
		.dec    (dec),
		.taken  (br_taken),
		.target (br_target)
	);

	writeback_reg u_wb (
		.clk    (clk),
		.rst_n  (rst_n),
		.valid  (dec.valid),
		.rd     (dec.rd),
		.result (alu_result),
		.rd_wr  (alu_rd_wr),
		.taken  (br_taken),
		.target (br_target),
		.wb     (wb),
		.redir  (redir)
	);

endmodule

// File: src/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import rv_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   instr_valid,
	input  instr_t instr,
	input  data_t  pc,
	input  data_t  rs1_data,
	input  data_t  rs2_data,
	output dec_t   dec
);

	data_t imm_i;
	data_t imm_s;
	data_t imm_b;
	data_t imm_u;
	data_t imm_j;
	data_t imm;
	data_t op_a;
	data_t op_b;

	always_comb begin : imm_gen
		imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
		imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
		imm_b = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
		imm_u = {instr.u.imm, 12'b0};
		imm_j = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};
	end

	always_comb begin : operand_sel
		op_a = rs1_data;
		op_b = rs2_data;
		imm  = '0;
		unique case (instr.r.opcode)
			I, LOAD: begin
				op_b = imm_i;
				imm  = imm_i;
			end
			STORE: begin
				op_b = imm_s;
				imm  = imm_s;
			end
			B: imm = imm_b;          // b stays rs2 for the compare
			LUI: begin
				op_b = imm_u;
				imm  = imm_u;
			end
			AUIPC: begin
				op_a = pc;
				op_b = imm_u;
				imm  = imm_u;
			end
			JAL: begin
				op_a = pc;
				op_b = data_t'(4);   // link address pc+4
				imm  = imm_j;
			end
			JALR: begin
				op_a = pc;
				op_b = data_t'(4);
				imm  = imm_i;        // target uses rs1_val+imm
			end
			default: ;               // R, MEM, SYS keep register operands
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid   <= instr_valid;
			dec.opcode  <= instr.r.opcode;
			dec.funct3  <= instr.r.funct3;
			dec.alt     <= instr.r.funct7[5];
			dec.rd      <= instr.r.rd;
			dec.a       <= op_a;
			dec.b       <= op_b;
			dec.rs1_val <= rs1_data;
			dec.rs2_val <= rs2_data;
			dec.pc      <= pc;
			dec.imm     <= imm;
		end
	end

	// anything outside the opcode map would reach the ALU as a silent no-op
	a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
		dec.valid |-> dec.opcode inside {R, I, LOAD, STORE, B, JAL, JALR, LUI, AUIPC, MEM, SYS})
		else $error("instr_decode: unknown opcode %b captured", dec.opcode);

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [2:0]      funct3_t;

	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		B     = 7'b1100011,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		MEM   = 7'b0001111, // fence
		SYS   = 7'b1110011
	} opcode_t;

	`include "alu_define.svh"

	// one word, six format views
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			funct3_t    funct3;
			logic [4:0] rd;
			opcode_t    opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			funct3_t     funct3;
			logic [4:0]  rd;
			opcode_t     opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			funct3_t    funct3;
			logic [4:0] imm_lo;
			opcode_t    opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			funct3_t    funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			opcode_t    opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			opcode_t     opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			opcode_t    opcode;
		} j;
	} instr_t;

	typedef struct packed {
		logic       valid;
		opcode_t    opcode;
		funct3_t    funct3;
		logic       alt;     // instruction bit 30
		logic [4:0] rd;
		data_t      a;
		data_t      b;
		data_t      rs1_val;
		data_t      rs2_val;
		data_t      pc;
		data_t      imm;
	} dec_t;

	typedef struct packed {
		logic       valid;
		logic [4:0] rd;
		logic       rd_we;
		data_t      result;
	} wb_t;

	typedef struct packed {
		logic  taken;
		data_t target;
	} redir_t;

endpackage

// File: src/writeback_reg.sv
`timescale 1ns/1ps

module writeback_reg import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       valid,
	input  logic [4:0] rd,
	input  data_t      result,
	input  logic       rd_wr,
	input  logic       taken,
	input  data_t      target,
	output wb_t        wb,
	output redir_t     redir
);

	logic rd_we_d;

	always_comb begin
		rd_we_d = valid & rd_wr & (rd != 5'd0); // x0 stays zero
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb.valid    <= 1'b0;
			wb.rd_we    <= 1'b0;
			redir.taken <= 1'b0;
		end else begin
			wb.valid     <= valid;
			wb.rd        <= rd;
			wb.rd_we     <= rd_we_d;
			wb.result    <= result;
			redir.taken  <= valid & taken;
			redir.target <= target;
		end
	end

endmodule

// File: testbench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period  = 2;  // 4 ns clock
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1;  // release clear of the edge
	end

endmodule

// File: testbench/tb_exec_top.sv
`timescale 1ns/1ps

module tb_exec_top import rv_pkg::*; ();

	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_i      = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam int drive_delay = 1;
	localparam int clk_period  = 4;

	typedef struct packed {
		logic        valid;
		logic [31:0] word;
		logic [31:0] pc;
		logic [31:0] rs1;
		logic [31:0] rs2;
	} row_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic        rd_we;
		logic        check_res;  // result has a defined value
		logic [31:0] result;
		logic        taken;
		logic [31:0] target;
	} exp_t;

	logic   clk;
	logic   rst_n;
	logic   instr_valid;
	instr_t instr;
	data_t  pc;
	data_t  rs1_data;
	data_t  rs2_data;
	wb_t    wb;
	redir_t redir;

	row_t        rows[$];
	logic [31:0] next_pc     = 32'h0000_1000;
	int          seed        = 32'haca1_5764;
	bit          table_built = 1'b0;

	clk_gen u_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	exec_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.wb          (wb),
		.redir       (redir)
	);

	// rs1 is always x1 and rs2 x2, the values come from the table
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd);
		return {f7, 5'd2, 5'd1, f3, rd, op_r};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
			input logic [4:0] rd, input logic [11:0] imm);
		return {imm, 5'd1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [11:0] imm);
		return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [12:0] imm);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	function automatic logic [31:0] alu_reference(input logic [2:0] f3, input logic sub,
			input logic arith, input logic [31:0] a, input logic [31:0] b);
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: return sub ? a - b : a + b;
			3'b001: return a << sh;
			3'b010: return {31'd0, $signed(a) < $signed(b)};
			3'b011: return {31'd0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (arith)
					return $unsigned($signed(a) >>> sh);
				return a >> sh;
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic exp_t compute_expected(input row_t r);
		exp_t        e;
		logic [31:0] w;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic        cond;
		w     = r.word;
		e     = '0;
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'd0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		if (!r.valid)
			return e;  // bubble
		e.valid     = 1'b1;
		e.rd        = w[11:7];
		e.rd_we     = 1'b1;
		e.check_res = 1'b1;
		case (w[6:0])
			op_r:     e.result = alu_reference(w[14:12], w[30], w[30], r.rs1, r.rs2);
			op_i:     e.result = alu_reference(w[14:12], 1'b0, w[30], r.rs1, imm_i);
			op_load:  e.result = r.rs1 + imm_i;
			op_lui:   e.result = imm_u;
			op_auipc: e.result = r.pc + imm_u;
			op_store: begin
				e.result = r.rs1 + imm_s;
				e.rd_we  = 1'b0;
			end
			op_jal: begin
				e.result = r.pc + 32'd4;
				e.taken  = 1'b1;
				e.target = r.pc + imm_j;
			end
			op_jalr: begin
				e.result = r.pc + 32'd4;
				e.taken  = 1'b1;
				e.target = (r.rs1 + imm_i) & ~32'd1;
			end
			op_branch: begin
				case (w[14:12])
					3'b000:  cond = r.rs1 == r.rs2;
					3'b001:  cond = r.rs1 != r.rs2;
					3'b100:  cond = $signed(r.rs1) < $signed(r.rs2);
					3'b101:  cond = $signed(r.rs1) >= $signed(r.rs2);
					3'b110:  cond = r.rs1 < r.rs2;
					default: cond = r.rs1 >= r.rs2;
				endcase
				e.rd_we     = 1'b0;
				e.check_res = 1'b0;
				e.taken     = cond;
				e.target    = r.pc + imm_b;
			end
			default: begin
				e.rd_we     = 1'b0;
				e.check_res = 1'b0;
			end
		endcase
		if (e.rd == 5'd0)
			e.rd_we = 1'b0;  // x0 is never written
		return e;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("error at %0d ns: %s expected %h got %h", $time, what, expected, got);
			$display("ERRORS FOUND");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic compare_outputs(input exp_t e, input int idx);
		string tag;
		tag = (idx < 0) ? "idle slot" : $sformatf("row %0d", idx);
		check_value({tag, " wb.valid"}, 32'(wb.valid), 32'(e.valid));
		check_value({tag, " wb.rd_we"}, 32'(wb.rd_we), 32'(e.rd_we));
		check_value({tag, " redir.taken"}, 32'(redir.taken), 32'(e.taken));
		if (e.valid)
			check_value({tag, " wb.rd"}, 32'(wb.rd), 32'(e.rd));
		if (e.check_res)
			check_value({tag, " wb.result"}, wb.result, e.result);
		if (e.taken)
			check_value({tag, " redir.target"}, redir.target, e.target);
	endtask

	task automatic push_row(input logic valid, input logic [31:0] word,
			input logic [31:0] rs1, input logic [31:0] rs2);
		row_t r;
		r       = '{valid, word, next_pc, rs1, rs2};
		next_pc = next_pc + 32'd4;
		rows.push_back(r);
	endtask

	task automatic add_row(input logic [31:0] word, input logic [31:0] rs1,
			input logic [31:0] rs2);
		push_row(1'b1, word, rs1, rs2);
	endtask

	task automatic build_table();
		add_row(r_type(7'h00, 3'b000, 5'd5), $random(seed), $random(seed));   // add
		add_row(r_type(7'h20, 3'b000, 5'd6), $random(seed), $random(seed));   // sub
		add_row(r_type(7'h00, 3'b111, 5'd7), $random(seed), $random(seed));   // and
		add_row(r_type(7'h00, 3'b110, 5'd8), $random(seed), $random(seed));   // or
		add_row(r_type(7'h00, 3'b100, 5'd9), $random(seed), $random(seed));   // xor
		add_row(r_type(7'h00, 3'b010, 5'd10), 32'hffff_fffb, 32'd3);          // slt -5 < 3
		add_row(r_type(7'h00, 3'b010, 5'd10), 32'd3, 32'hffff_fffb);
		add_row(r_type(7'h00, 3'b011, 5'd11), 32'hffff_fffb, 32'd3);          // sltu, huge a
		add_row(r_type(7'h00, 3'b011, 5'd11), 32'd3, 32'hffff_fffb);
		add_row(r_type(7'h00, 3'b001, 5'd12), $random(seed), 32'd36);         // only 5 bits count
		add_row(r_type(7'h00, 3'b101, 5'd13), 32'h8000_00f0, 32'd4);          // srl
		add_row(r_type(7'h20, 3'b101, 5'd14), 32'h8000_00f0, 32'd4);          // sra
		add_row(i_type(op_i, 3'b000, 5'd15, 12'hff9), $random(seed), 32'd0);  // addi -7
		add_row(i_type(op_i, 3'b111, 5'd16, 12'h0f0), $random(seed), 32'd0);
		add_row(i_type(op_i, 3'b110, 5'd17, 12'h800), $random(seed), 32'd0);  // ori, sign only
		add_row(i_type(op_i, 3'b100, 5'd18, 12'hfff), $random(seed), 32'd0);  // xori -1
		add_row(i_type(op_i, 3'b010, 5'd19, 12'hffe), 32'hffff_fffd, 32'd0);  // slti -3 < -2
		add_row(i_type(op_i, 3'b011, 5'd20, 12'hfff), 32'd5, 32'd0);          // sltiu vs all ones
		add_row(i_type(op_i, 3'b001, 5'd21, 12'h007), $random(seed), 32'd0);  // slli
		add_row(i_type(op_i, 3'b101, 5'd22, 12'h008), 32'hf000_0000, 32'd0);  // srli
		add_row(i_type(op_i, 3'b101, 5'd23, 12'h408), 32'hf000_0000, 32'd0);  // srai
		add_row(u_type(op_lui, 5'd24, 20'habcde), 32'd0, 32'd0);
		add_row(u_type(op_auipc, 5'd25, 20'h12345), 32'd0, 32'd0);
		add_row(i_type(op_load, 3'b010, 5'd26, 12'hffc), 32'h0000_2000, 32'd0);  // lw -4
		add_row(s_type(3'b010, 12'h7fc), 32'h0000_3000, $random(seed));        // sw
		add_row(b_type(3'b000, 13'h0040), 32'h1234_5678, 32'h1234_5678);      // beq
		add_row(b_type(3'b000, 13'h0040), 32'h1234_5678, 32'h1234_5679);
		add_row(b_type(3'b001, 13'h1ff0), 32'd1, 32'd2);                      // bne backwards
		add_row(b_type(3'b001, 13'h1ff0), 32'd7, 32'd7);
		add_row(b_type(3'b100, 13'h0100), 32'hffff_ffff, 32'd1);              // blt -1 < 1
		add_row(b_type(3'b100, 13'h0100), 32'd1, 32'hffff_ffff);
		add_row(b_type(3'b101, 13'h0ffe), 32'd1, 32'hffff_ffff);              // bge
		add_row(b_type(3'b101, 13'h0ffe), 32'hffff_ffff, 32'd1);
		add_row(b_type(3'b110, 13'h0008), 32'd1, 32'hffff_ffff);              // bltu
		add_row(b_type(3'b110, 13'h0008), 32'hffff_ffff, 32'd1);
		add_row(b_type(3'b111, 13'h1000), 32'hffff_ffff, 32'd1);              // bgeu, -4096
		add_row(b_type(3'b111, 13'h1000), 32'd1, 32'hffff_ffff);
		add_row(j_type(5'd1, 21'h1ffff0), 32'd0, 32'd0);                      // jal backwards
		add_row(j_type(5'd1, 21'h000800), 32'd0, 32'd0);
		add_row(i_type(op_jalr, 3'b000, 5'd1, 12'h007), 32'h0000_5000, 32'd0);  // odd sum
		add_row(i_type(op_jalr, 3'b000, 5'd1, 12'hffd), $random(seed), 32'd0);
		add_row(r_type(7'h00, 3'b000, 5'd0), $random(seed), $random(seed));   // add to x0
		add_row(j_type(5'd0, 21'h000010), 32'd0, 32'd0);                      // j, no link
		push_row(1'b0, j_type(5'd1, 21'h000010), 32'd0, 32'd0);               // idle jal word
		push_row(1'b0, r_type(7'h00, 3'b000, 5'd3), 32'd1, 32'd1);
		add_row(r_type(7'h00, 3'b000, 5'd4), $random(seed), $random(seed));
	endtask

	task automatic drive_row(input row_t r);
		instr_valid = r.valid;
		instr       = r.word;
		pc          = r.pc;
		rs1_data    = r.rs1;
		rs2_data    = r.rs2;
	endtask

	initial begin : watchdog
		wait (table_built);
		#((rows.size() + 20) * clk_period);
		$display("ERRORS FOUND");
		$fatal(1, "timeout, the pipeline did not finish %0d rows in time", rows.size());
	end

	initial begin : main
		exp_t e_d1;
		exp_t e_d2;
		int   idx_d1;
		int   idx_d2;
		int   cyc;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		rs1_data    = '0;
		rs2_data    = '0;
		build_table();
		table_built = 1'b1;
		e_d1   = '0;
		e_d2   = '0;
		idx_d1 = -1;
		idx_d2 = -1;
		wait (rst_n === 1'b1);
		compare_outputs(e_d2, idx_d2);  // outputs idle out of reset
		for (cyc = 0; cyc < rows.size() + 2; cyc++) begin
			@(posedge clk);
			#(drive_delay);
			compare_outputs(e_d2, idx_d2);  // entry driven two cycles ago
			e_d2   = e_d1;
			idx_d2 = idx_d1;
			if (cyc < rows.size()) begin
				e_d1   = compute_expected(rows[cyc]);
				idx_d1 = cyc;
				drive_row(rows[cyc]);
			end else begin
				e_d1        = '0;
				idx_d1      = -1;
				instr_valid = 1'b0;
			end
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule
